//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ppu_out
FILELIST  ?= n64_ppu_out.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_ppu_out.sv
`timescale 1ns/1ns

module tb_ppu_out;

  import ppu_cfg_pkg::*;
  import ppu_video_pkg::*;

  logic     VCLK_Tx = 1'b0;
  logic     nVRST_Tx;
  ppu_cfg_t cfg_i;
  logic     palmode_i;
  vid_bus_t vid_i;
  vid_bus_t vid_o;
  vmode_e   vmode_o;

  // Reference pipeline, one entry per cycle of video latency
  vid_bus_t exp_pipe [5];
  vid_bus_t exp_vid;
  vmode_e   exp_vmode;
  ppu_cfg_t cfg_q;
  int       settle;
  int       cur_line;
  int       cur_col;
  int       seed = 77;
  int       errors;
  int       err_mark;
  int       tests;

  ppu_out_top u_dut (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .cfg_i     (cfg_i),
    .palmode_i (palmode_i),
    .vid_i     (vid_i),
    .vid_o     (vid_o),
    .vmode_o   (vmode_o)
  );

  always #20 VCLK_Tx = ~VCLK_Tx;

  // ======================================================================
  // Reference model
  // ======================================================================

  function automatic vmode_e mode_ref(input ppu_cfg_t c, input logic pal);
    logic   use_pal;
    vmode_e m;
    use_pal = pal;
    if (c.force60 && !c.low_latency && c.target_res != TGT_288P)
      use_pal = 1'b0;
    else if (c.force50 && !c.low_latency && c.target_res != TGT_240P)
      use_pal = 1'b1;
    case (c.target_res)
      TGT_720P:  m = use_pal ? VM_720P50 : VM_720P60;
      TGT_960P:  m = use_pal ? VM_960P50 : VM_960P60;
      TGT_1080P: m = use_pal ? VM_1080P50 : VM_1080P60;
      TGT_1200P: m = use_pal ? VM_1200P50 : VM_1200P60;
      TGT_1440P: m = use_pal ? VM_1440P50 : VM_1440P60;
      TGT_240P:  m = use_pal ? VM_576P50 : VM_240P60;
      TGT_288P:  m = use_pal ? VM_288P50 : (c.use_vga_480p ? VM_VGAP60 : VM_480P60);
      default:   m = use_pal ? VM_576P50 : (c.use_vga_480p ? VM_VGAP60 : VM_480P60);
    endcase
    return m;
  endfunction

  // Strength str * 16 + 15 out of 256
  function automatic logic [7:0] darken_ref(input logic [7:0] ch, input logic [3:0] str);
    int s;
    int v;
    s = int'(str) * 16 + 15;
    v = int'(ch) - (int'(ch) * s) / 256;
    return v[7:0];
  endfunction

  function automatic logic [7:0] limit_ref(input logic [7:0] ch);
    int a;
    int b;
    a = (int'(ch) * 220) >> 7;
    b = (a >> 1) + (a & 1) + 16;
    return b[7:0];
  endfunction

  function automatic vid_bus_t pixel_ref(input vid_bus_t v, input int line, input int col,
                                         input ppu_cfg_t c);
    vid_bus_t   o;
    logic [7:0] ch [3];
    logic       v_en;
    logic [3:0] v_str;
    v_en  = c.h2v_linked ? c.hsl_en : c.vsl_en;
    v_str = c.h2v_linked ? c.hsl_str : c.vsl_str;
    ch[0] = v.rgb.re;
    ch[1] = v.rgb.gr;
    ch[2] = v.rgb.bl;
    for (int i = 0; i < 3; i++) begin
      // Columns first, then lines, then range
      if (v.de && v_en && col[0])
        ch[i] = darken_ref(ch[i], v_str);
      if (v.de && c.hsl_en && line[0])
        ch[i] = darken_ref(ch[i], c.hsl_str);
      if (c.limited_rgb)
        ch[i] = limit_ref(ch[i]);
    end
    o        = v;
    o.rgb.re = ch[0];
    o.rgb.gr = ch[1];
    o.rgb.bl = ch[2];
    return o;
  endfunction

  always @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < 5; i++)
        exp_pipe[i] <= '0;
      exp_vmode <= VM_480P60;
      cfg_q     <= '0;
      settle    <= 0;
    end else begin
      exp_pipe[0] <= pixel_ref(vid_i, cur_line, cur_col, cfg_i);
      for (int i = 1; i < 5; i++)
        exp_pipe[i] <= exp_pipe[i-1];
      exp_vmode <= mode_ref(cfg_i, palmode_i);
      cfg_q     <= cfg_i;
      // Pixels in flight see a mix of old and new settings
      if (cfg_i != cfg_q)
        settle <= 8;
      else if (settle != 0)
        settle <= settle - 1;
    end
  end

  assign exp_vid = exp_pipe[4];

  a_vid_o: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx || settle != 0)
    vid_o == exp_vid)
    else begin
      errors++;
      $display("[ERROR] vid_o: got %h, expected %h", $sampled(vid_o), $sampled(exp_vid));
    end

  a_vmode_o: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    vmode_o == exp_vmode)
    else begin
      errors++;
      $display("[ERROR] vmode_o: got %h, expected %h", $sampled(vmode_o), $sampled(exp_vmode));
    end

  // ======================================================================
  // Stimulus
  // ======================================================================

  task automatic drive_px(input logic vs, input logic hs, input logic de, input rgb_t px,
                          input int line, input int col);
    @(posedge VCLK_Tx);
    #2;
    vid_i.vsync = vs;
    vid_i.hsync = hs;
    vid_i.de    = de;
    vid_i.rgb   = px;
    cur_line    = line;
    cur_col     = col;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_px(1'b0, 1'b0, 1'b0, '0, 0, 0);
  endtask

  task automatic set_cfg(input ppu_cfg_t c, input logic pal);
    @(posedge VCLK_Tx);
    #2;
    cfg_i     = c;
    palmode_i = pal;
  endtask

  task automatic wait_output_idle();
    int n;
    n = 0;
    while (vid_o.de) begin
      @(posedge VCLK_Tx);
      #2;
      n++;
      if (n > 16) begin
        $display("timed out waiting for the video output to go idle");
        $display("Test failed");
        $finish;
      end
    end
  endtask

  // Vsync, then per line an hsync cycle, a blank and the active pixels
  task automatic send_frame(input int lines, input int cols);
    logic [31:0] rnd;
    rgb_t        px;
    repeat (2) drive_px(1'b1, 1'b0, 1'b0, '0, 0, 0);
    for (int l = 0; l < lines; l++) begin
      drive_px(1'b0, 1'b1, 1'b0, '0, l, 0);
      drive_px(1'b0, 1'b0, 1'b0, '0, l, 0);
      for (int c = 0; c < cols; c++) begin
        rnd = $random(seed);
        px  = rnd[23:0];
        drive_px(1'b0, 1'b0, 1'b1, px, l, c);
      end
    end
    drive_px(1'b0, 1'b0, 1'b0, '0, 0, 0);
    wait_output_idle();
  endtask

  task automatic close_test(input string name);
    $display("%s: done, %0d errors", name, errors - err_mark);
    err_mark = errors;
    tests++;
  endtask

  initial begin
    ppu_cfg_t c;
    nVRST_Tx  = 1'b0;
    cfg_i     = '0;
    palmode_i = 1'b0;
    vid_i     = '0;
    cur_line  = 0;
    cur_col   = 0;
    errors    = 0;
    err_mark  = 0;
    tests     = 0;
    repeat (10) @(posedge VCLK_Tx);
    #2;
    nVRST_Tx = 1'b1;
    idle(2);

    a_reset_vid: assert (vid_o == '0) else begin
      errors++;
      $display("[ERROR] vid_o: got %h, expected %h", vid_o, 27'h0);
    end
    a_reset_mode: assert (vmode_o == VM_480P60) else begin
      errors++;
      $display("[ERROR] vmode_o: got %h, expected %h", vmode_o, VM_480P60);
    end
    close_test("reset");

    // Plain table, both columns
    for (int t = 0; t < 8; t++) begin
      for (int p = 0; p < 4; p++) begin
        c = '0;
        c.target_res   = target_res_e'(t[2:0]);
        c.use_vga_480p = p[1];
        set_cfg(c, p[0]);
        idle(1);
      end
    end
    // Forcing against low latency and the native line count
    for (int t = 0; t < 8; t++) begin
      for (int f = 1; f < 4; f++) begin
        for (int k = 0; k < 4; k++) begin
          c = '0;
          c.target_res  = target_res_e'(t[2:0]);
          c.force60     = f[0];
          c.force50     = f[1];
          c.low_latency = k[1];
          set_cfg(c, k[0]);
          idle(1);
        end
      end
    end
    close_test("mode decode");

    set_cfg('0, 1'b0);
    idle(10);
    send_frame(3, 8);
    close_test("bypass");

    c = '0;
    c.limited_rgb = 1'b1;
    set_cfg(c, 1'b0);
    idle(10);
    send_frame(4, 8);
    close_test("limited range");

    c = '0;
    c.hsl_en  = 1'b1;
    c.hsl_str = 4'($random(seed));
    set_cfg(c, 1'b0);
    idle(10);
    send_frame(5, 9);
    c.hsl_str = 4'hF;
    set_cfg(c, 1'b0);
    idle(10);
    send_frame(4, 7);
    close_test("horizontal scanlines");

    c = '0;
    c.vsl_en  = 1'b1;
    c.vsl_str = 4'd5;
    set_cfg(c, 1'b0);
    idle(10);
    send_frame(3, 9);
    // Linked, vertical takes the horizontal enable and strength
    c.hsl_en     = 1'b1;
    c.hsl_str    = 4'd12;
    c.vsl_en     = 1'b0;
    c.vsl_str    = 4'd3;
    c.h2v_linked = 1'b1;
    set_cfg(c, 1'b0);
    idle(10);
    send_frame(4, 8);
    c.hsl_en = 1'b0;
    c.vsl_en = 1'b1;
    set_cfg(c, 1'b0);
    idle(10);
    send_frame(3, 8);
    close_test("vertical scanlines");

    idle(8);
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial begin
    #1000000;
    $display("simulation ran past its time limit");
    $display("Test failed");
    $finish;
  end

endmodule

//--- n64_ppu_out.f
+incdir+verilog
verilog/ppu_cfg_pkg.sv
verilog/ppu_video_pkg.sv
verilog/ppu_cfg_decode.sv
verilog/scanline_emu.sv
verilog/rgb_range_out.sv
verilog/ppu_out_top.sv
bench/tb_ppu_out.sv

//--- verilog/ppu_cfg_decode.sv
`timescale 1ns/1ns
`include "ppu_defs.svh"

module ppu_cfg_decode (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  ppu_cfg_pkg::ppu_cfg_t cfg_i,
  input  logic                  palmode_i,
  output ppu_cfg_pkg::vmode_e   vmode_o,
  output ppu_cfg_pkg::sl_cfg_t  hsl_o,
  output ppu_cfg_pkg::sl_cfg_t  vsl_o,
  output logic                  limited_rgb_o
);

  import ppu_cfg_pkg::*;

  vmode_e  vmode_ntsc;
  vmode_e  vmode_pal;
  logic    force_ntsc;
  logic    force_pal;
  sl_cfg_t hsl_next;
  sl_cfg_t vsl_next;

  // Menu strength 0..15 onto 15..255
  function automatic logic [`PPU_SL_STR_W-1:0] expand_str(input logic [3:0] str);
    return {str, 4'hF};
  endfunction

  // ======================================================================
  // Mode candidates
  // ======================================================================

  always_comb begin
    case (cfg_i.target_res)
      TGT_720P:  vmode_ntsc = VM_720P60;
      TGT_960P:  vmode_ntsc = VM_960P60;
      TGT_1080P: vmode_ntsc = VM_1080P60;
      TGT_1200P: vmode_ntsc = VM_1200P60;
      TGT_1440P: vmode_ntsc = VM_1440P60;
      TGT_240P:  vmode_ntsc = VM_240P60;
      // 480p and 288p
      default:   vmode_ntsc = cfg_i.use_vga_480p ? VM_VGAP60 : VM_480P60;
    endcase
  end

  always_comb begin
    case (cfg_i.target_res)
      TGT_480P,
      TGT_576P:  vmode_pal = VM_576P50;
      TGT_720P:  vmode_pal = VM_720P50;
      TGT_960P:  vmode_pal = VM_960P50;
      TGT_1080P: vmode_pal = VM_1080P50;
      TGT_1200P: vmode_pal = VM_1200P50;
      TGT_1440P: vmode_pal = VM_1440P50;
      default:   vmode_pal = VM_288P50;
    endcase
  end

  // No forcing in low latency mode or against the native line count
  assign force_ntsc = cfg_i.force60 & ~cfg_i.low_latency & (cfg_i.target_res != TGT_288P);
  assign force_pal  = cfg_i.force50 & ~cfg_i.low_latency & (cfg_i.target_res != TGT_240P);

  // Vertical scanline settings may follow the horizontal ones
  always_comb begin
    hsl_next.en  = cfg_i.hsl_en;
    hsl_next.str = expand_str(cfg_i.hsl_str);
    if (cfg_i.h2v_linked) begin
      vsl_next = hsl_next;
    end else begin
      vsl_next.en  = cfg_i.vsl_en;
      vsl_next.str = expand_str(cfg_i.vsl_str);
    end
  end

  // ======================================================================
  // Registered settings
  // ======================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vmode_o       <= VM_480P60;
      hsl_o         <= '0;
      vsl_o         <= '0;
      limited_rgb_o <= 1'b0;
    end else begin
      if (force_ntsc)
        vmode_o <= vmode_ntsc;
      else if (force_pal)
        vmode_o <= vmode_pal;
      else if (palmode_i)
        vmode_o <= vmode_pal;
      else
        vmode_o <= vmode_ntsc;
      hsl_o         <= hsl_next;
      vsl_o         <= vsl_next;
      limited_rgb_o <= cfg_i.limited_rgb;
    end
  end

  // A 60 Hz force never selects a 50 Hz mode
  a_force60_rate: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $past(force_ntsc) |-> (vmode_o <= VM_240P60));

endmodule

//--- verilog/ppu_cfg_pkg.sv
`include "ppu_defs.svh"

package ppu_cfg_pkg;

  // Output resolution as picked in the menu
  typedef enum logic [2:0] {
    TGT_480P  = 3'd0,
    TGT_720P  = 3'd1,
    TGT_960P  = 3'd2,
    TGT_1080P = 3'd3,
    TGT_1200P = 3'd4,
    TGT_1440P = 3'd5,
    TGT_240P  = 3'd6,
    TGT_288P  = 3'd7
  } target_res_e;

  // PAL reuses the 240p code for 576p
  localparam target_res_e TGT_576P = TGT_240P;

  // Video mode handed to the timing generator
  typedef enum logic [3:0] {
    VM_480P60  = 4'd0,
    VM_VGAP60  = 4'd1,
    VM_720P60  = 4'd2,
    VM_960P60  = 4'd3,
    VM_1080P60 = 4'd4,
    VM_1200P60 = 4'd5,
    VM_1440P60 = 4'd6,
    VM_240P60  = 4'd7,
    VM_576P50  = 4'd8,
    VM_720P50  = 4'd9,
    VM_960P50  = 4'd10,
    VM_1080P50 = 4'd11,
    VM_1200P50 = 4'd12,
    VM_1440P50 = 4'd13,
    VM_288P50  = 4'd14
  } vmode_e;

  // Configuration word, MSB first
  typedef struct packed {
    target_res_e target_res;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        low_latency;
    logic        hsl_en;
    logic [3:0]  hsl_str;
    logic        vsl_en;
    logic [3:0]  vsl_str;
    logic        h2v_linked;
    logic        limited_rgb;
  } ppu_cfg_t;

  // One scanline direction after decode
  typedef struct packed {
    logic                     en;
    logic [`PPU_SL_STR_W-1:0] str;
  } sl_cfg_t;

endpackage

//--- verilog/ppu_defs.svh
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// ======================================================================
// Pixel format
// ======================================================================

// Bits per colour channel at the transmitter
`define PPU_COLOR_W 8

// ======================================================================
// Limited range RGB
// ======================================================================

// Full scale 0..255 is compressed by 220/256 and lifted by the offset,
// which lands every channel in 16..235
`define PPU_LIMRGB_COEFF 220

// Black level for limited range
`define PPU_LIMRGB_OFFSET 16

// ======================================================================
// Scanlines
// ======================================================================

// Strength after expansion from the 4 bit menu value
`define PPU_SL_STR_W 8

`endif

//--- verilog/ppu_out_top.sv
`timescale 1ns/1ns

module ppu_out_top (
  input  logic                    VCLK_Tx,
  input  logic                    nVRST_Tx,
  input  ppu_cfg_pkg::ppu_cfg_t   cfg_i,
  input  logic                    palmode_i,
  input  ppu_video_pkg::vid_bus_t vid_i,
  output ppu_video_pkg::vid_bus_t vid_o,
  output ppu_cfg_pkg::vmode_e     vmode_o
);

  import ppu_cfg_pkg::*;
  import ppu_video_pkg::*;

  sl_cfg_t  hsl;
  sl_cfg_t  vsl;
  logic     limited_rgb;
  vid_bus_t vid_vsl;
  vid_bus_t vid_hsl;

  // ======================================================================
  // Configuration
  // ======================================================================

  ppu_cfg_decode u_cfg_decode (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg_i),
    .palmode_i     (palmode_i),
    .vmode_o       (vmode_o),
    .hsl_o         (hsl),
    .vsl_o         (vsl),
    .limited_rgb_o (limited_rgb)
  );

  // ======================================================================
  // Video path, 1 + 1 + 3 cycles
  // ======================================================================

  // Columns first
  scanline_emu #(
    .SL_VERTICAL (1'b1)
  ) u_vsl_emu (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .vid_i    (vid_i),
    .sl_i     (vsl),
    .vid_o    (vid_vsl)
  );

  // then lines
  scanline_emu #(
    .SL_VERTICAL (1'b0)
  ) u_hsl_emu (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .vid_i    (vid_vsl),
    .sl_i     (hsl),
    .vid_o    (vid_hsl)
  );

  rgb_range_out u_rgb_out (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .vid_i         (vid_hsl),
    .limited_rgb_i (limited_rgb),
    .vid_o         (vid_o)
  );

endmodule

//--- verilog/ppu_video_pkg.sv
`include "ppu_defs.svh"

package ppu_video_pkg;

  // ======================================================================
  // Pixel and video bus
  // ======================================================================

  // One RGB pixel
  typedef struct packed {
    logic [`PPU_COLOR_W-1:0] re;
    logic [`PPU_COLOR_W-1:0] gr;
    logic [`PPU_COLOR_W-1:0] bl;
  } rgb_t;

  // Sync, data enable and pixel of one clock, sync active high
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
    rgb_t rgb;
  } vid_bus_t;

endpackage

//--- verilog/rgb_range_out.sv
`timescale 1ns/1ns
`include "ppu_defs.svh"

module rgb_range_out (
  input  logic                    VCLK_Tx,
  input  logic                    nVRST_Tx,
  input  ppu_video_pkg::vid_bus_t vid_i,
  input  logic                    limited_rgb_i,
  output ppu_video_pkg::vid_bus_t vid_o
);

  import ppu_video_pkg::*;

  localparam int CW = `PPU_COLOR_W;
  localparam logic [CW-1:0] LIM_COEFF  = `PPU_LIMRGB_COEFF;
  localparam logic [CW-1:0] LIM_OFFSET = `PPU_LIMRGB_OFFSET;
  localparam int            LIM_MAX    = `PPU_LIMRGB_COEFF + `PPU_LIMRGB_OFFSET - 1;

  logic [CW-1:0]   chan_in [3];
  logic [2*CW-1:0] prod    [3];
  logic [CW:0]     lim_s1  [3];
  logic [CW-1:0]   lim_s2  [3];
  vid_bus_t        full_s1;
  vid_bus_t        full_s2;
  rgb_t            lim_rgb;

  assign chan_in[0] = vid_i.rgb.re;
  assign chan_in[1] = vid_i.rgb.gr;
  assign chan_in[2] = vid_i.rgb.bl;

  always_comb begin
    for (int i = 0; i < 3; i++)
      prod[i] = chan_in[i] * LIM_COEFF;
  end

  // Black level lift on the rounded value
  assign lim_rgb.re = lim_s2[0] + LIM_OFFSET;
  assign lim_rgb.gr = lim_s2[1] + LIM_OFFSET;
  assign lim_rgb.bl = lim_s2[2] + LIM_OFFSET;

  // ======================================================================
  // Three stage pipeline
  // ======================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < 3; i++) begin
        lim_s1[i] <= '0;
        lim_s2[i] <= '0;
      end
      full_s1 <= '0;
      full_s2 <= '0;
      vid_o   <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        // Product / 128, one extra bit kept for rounding
        lim_s1[i] <= prod[i][2*CW-1:CW-1];
        lim_s2[i] <= lim_s1[i][CW:1] + {{(CW-1){1'b0}}, lim_s1[i][0]};
      end
      full_s1 <= vid_i;
      full_s2 <= full_s1;

      vid_o.vsync <= full_s2.vsync;
      vid_o.hsync <= full_s2.hsync;
      vid_o.de    <= full_s2.de;
      vid_o.rgb   <= limited_rgb_i ? lim_rgb : full_s2.rgb;
    end
  end

  // Steady limited range keeps every channel inside 16..235
  a_limited_bounds: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $past(nVRST_Tx) && $past(limited_rgb_i) && $past(limited_rgb_i, 2) &&
    $past(limited_rgb_i, 3)
    |-> (vid_o.rgb.re inside {[LIM_OFFSET:LIM_MAX]}) &&
        (vid_o.rgb.gr inside {[LIM_OFFSET:LIM_MAX]}) &&
        (vid_o.rgb.bl inside {[LIM_OFFSET:LIM_MAX]}));

endmodule

//--- verilog/scanline_emu.sv
`timescale 1ns/1ns
`include "ppu_defs.svh"

module scanline_emu #(
  // 1 darkens pixel columns, 0 darkens lines
  parameter bit SL_VERTICAL = 1'b0
) (
  input  logic                    VCLK_Tx,
  input  logic                    nVRST_Tx,
  input  ppu_video_pkg::vid_bus_t vid_i,
  input  ppu_cfg_pkg::sl_cfg_t    sl_i,
  output ppu_video_pkg::vid_bus_t vid_o
);

  import ppu_video_pkg::*;

  logic pos_odd;
  logic sl_active;
  rgb_t rgb_dark;

  // ch - ch * str / 256, never below zero
  function automatic logic [`PPU_COLOR_W-1:0] dim(
    input logic [`PPU_COLOR_W-1:0]  ch,
    input logic [`PPU_SL_STR_W-1:0] str
  );
    logic [`PPU_COLOR_W+`PPU_SL_STR_W-1:0] prod;
    prod = ch * str;
    return ch - prod[`PPU_COLOR_W+`PPU_SL_STR_W-1:`PPU_SL_STR_W];
  endfunction

  // ======================================================================
  // Position parity
  // ======================================================================

  generate
    if (SL_VERTICAL) begin : g_column
      // Pixel count within the active line
      always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
        if (!nVRST_Tx)
          pos_odd <= 1'b0;
        else if (!vid_i.de)
          pos_odd <= 1'b0;
        else
          pos_odd <= ~pos_odd;
      end
    end else begin : g_line
      // Line count within the frame
      // vid_o.de holds the previous de, a fall ends a line
      always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
        if (!nVRST_Tx)
          pos_odd <= 1'b0;
        else if (vid_i.vsync)
          pos_odd <= 1'b0;
        else if (vid_o.de && !vid_i.de)
          pos_odd <= ~pos_odd;
      end
    end
  endgenerate

  // ======================================================================
  // Darkening and output register
  // ======================================================================

  assign sl_active = sl_i.en & pos_odd;

  always_comb begin
    rgb_dark.re = dim(vid_i.rgb.re, sl_i.str);
    rgb_dark.gr = dim(vid_i.rgb.gr, sl_i.str);
    rgb_dark.bl = dim(vid_i.rgb.bl, sl_i.str);
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vid_o <= '0;
    end else begin
      vid_o.vsync <= vid_i.vsync;
      vid_o.hsync <= vid_i.hsync;
      vid_o.de    <= vid_i.de;
      vid_o.rgb   <= sl_active ? rgb_dark : vid_i.rgb;
    end
  end

  // A scanline only ever takes light away
  a_dark_le_in: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $past(sl_active) |-> (vid_o.rgb.re <= $past(vid_i.rgb.re)) &&
                         (vid_o.rgb.gr <= $past(vid_i.rgb.gr)) &&
                         (vid_o.rgb.bl <= $past(vid_i.rgb.bl)));

endmodule
